//--- verilog/instQueuePkg.sv
package instQueuePkg;

    //////////////////////////////////////////////////
    // Entry layout
    //////////////////////////////////////////////////

    // Instruction address and next-fetch address share this width.
    localparam int addrWidth = 32;
    localparam int instWidth = 32;

    // Packed as {address, instruction, partial flag, next-fetch address}.
    localparam int entryWidth = 2 * addrWidth + instWidth + 1;

    //////////////////////////////////////////////////
    // Lanes and banks
    //////////////////////////////////////////////////

    // Slots in, banks and decode ports out. The rotators assume exactly four.
    localparam int laneCount = 4;

    localparam int bankDepth = 8;   // Per bank, so 32 entries in the queue.

    // Selects one bank out of laneCount.
    localparam int ptrWidth = $clog2(laneCount);

    // Holds 0 to laneCount, the number of instructions moved in one cycle.
    localparam int issueWidth = ptrWidth + 1;

    // Read and write pointers inside one bank.
    localparam int bankAddrWidth = $clog2(bankDepth);

    // Bank occupancy must reach bankDepth itself.
    localparam int countWidth = bankAddrWidth + 1;

    //////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////

    // A full group can still land in the cycle the request is seen, which leaves
    // one entry of headroom in every bank.
    localparam logic [countWidth-1:0] stopLevel = countWidth'(bankDepth - 1);

endpackage

//--- verilog/instQueueBank.sv
`timescale 1ns/100ps

module instQueueBank (
    input  logic                                Clk,
    input  logic                                rstN,
    input  logic                                clear,
    input  logic                                wrEn,
    input  logic [instQueuePkg::entryWidth-1:0] wrData,
    input  logic                                rdEn,
    output logic [instQueuePkg::entryWidth-1:0] rdData,
    output logic                                empty,
    output logic [instQueuePkg::countWidth-1:0] count
);

    logic [instQueuePkg::entryWidth-1:0]    mem [instQueuePkg::bankDepth];
    logic [instQueuePkg::bankAddrWidth-1:0] wrPtr;
    logic [instQueuePkg::bankAddrWidth-1:0] rdPtr;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0;   // Flush drops everything, including this cycle's traffic.
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;   // Depth is a power of two, so it wraps.
            end
            if (rdEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (wrEn) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Registered read port. The data holds until the next read.
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdData <= mem[rdPtr];
        end
    end

    assign empty = (count == '0);

endmodule

//--- verilog/instQueueCtrl.sv
`timescale 1ns/100ps

module instQueueCtrl (
    input  logic                                Clk,
    input  logic                                rstN,
    input  logic                                flush,
    input  logic                                stop,
    input  logic                                slotValid1,
    input  logic                                slotValid2,
    input  logic                                slotValid3,
    input  logic                                slotValid4,
    input  logic                                bankEmpty1,
    input  logic                                bankEmpty2,
    input  logic                                bankEmpty3,
    input  logic                                bankEmpty4,
    input  logic [instQueuePkg::countWidth-1:0] bankCount1,
    input  logic [instQueuePkg::countWidth-1:0] bankCount2,
    input  logic [instQueuePkg::countWidth-1:0] bankCount3,
    input  logic [instQueuePkg::countWidth-1:0] bankCount4,
    output logic [instQueuePkg::ptrWidth-1:0]   writePtr,
    output logic                                bankRdEn1,
    output logic                                bankRdEn2,
    output logic                                bankRdEn3,
    output logic                                bankRdEn4,
    output logic [instQueuePkg::ptrWidth-1:0]   outRotPtr,
    output logic [instQueuePkg::issueWidth-1:0] outCount,
    output logic                                reqStop
);

    logic [instQueuePkg::laneCount-1:0]  slotValid;
    logic [instQueuePkg::laneCount-1:0]  bankEmpty;
    logic [instQueuePkg::laneCount-1:0]  bankRdEn;
    logic [instQueuePkg::laneCount-1:0]  nearFull;
    logic [instQueuePkg::countWidth-1:0] bankCount [instQueuePkg::laneCount];
    logic [instQueuePkg::ptrWidth-1:0]   readPtr;   // Bank holding the oldest entry.
    logic [instQueuePkg::issueWidth-1:0] slotCount;
    logic [instQueuePkg::issueWidth-1:0] rdCount;

    assign slotValid = {slotValid4, slotValid3, slotValid2, slotValid1};
    assign bankEmpty = {bankEmpty4, bankEmpty3, bankEmpty2, bankEmpty1};
    assign bankCount = '{bankCount1, bankCount2, bankCount3, bankCount4};
    assign {bankRdEn4, bankRdEn3, bankRdEn2, bankRdEn1} = bankRdEn;

    // Valid slots form a prefix, so counting them gives the group size.
    always_comb begin
        slotCount = '0;
        for (int k = 0; k < instQueuePkg::laneCount; k++) begin
            if (slotValid[k]) begin
                slotCount = slotCount + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Walk the banks from readPtr and stop at the first empty one.
    always_comb begin
        logic [instQueuePkg::ptrWidth-1:0] bankIdx;
        logic                              run;
        rdCount = '0;
        run     = 1'b1;
        for (int k = 0; k < instQueuePkg::laneCount; k++) begin
            bankIdx = readPtr + k[instQueuePkg::ptrWidth-1:0];
            run     = run & ~bankEmpty[bankIdx];
            if (run) begin
                rdCount = rdCount + 1'b1;
            end
        end
    end

    always_comb begin
        logic [instQueuePkg::ptrWidth-1:0] offset;
        for (int b = 0; b < instQueuePkg::laneCount; b++) begin
            offset      = b[instQueuePkg::ptrWidth-1:0] - readPtr;
            bankRdEn[b] = ({1'b0, offset} < rdCount) && !stop && !flush;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            writePtr  <= '0;
            readPtr   <= '0;
            outRotPtr <= '0;
            outCount  <= '0;
        end else if (flush) begin
            writePtr  <= '0;
            readPtr   <= '0;
            outRotPtr <= '0;
            outCount  <= '0;
        end else begin
            writePtr  <= writePtr + slotCount[instQueuePkg::ptrWidth-1:0];   // Mod four.
            outRotPtr <= readPtr;   // The output stage rotates from the read start.
            if (stop) begin
                outCount <= '0;
            end else begin
                readPtr  <= readPtr + rdCount[instQueuePkg::ptrWidth-1:0];
                outCount <= rdCount;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < instQueuePkg::laneCount; b++) begin
            nearFull[b] = (bankCount[b] >= instQueuePkg::stopLevel);
        end
    end

    assign reqStop = |nearFull;

endmodule

//--- verilog/instWriteRotator.sv
`timescale 1ns/100ps

module instWriteRotator (
    input  logic [instQueuePkg::ptrWidth-1:0]   writePtr,
    input  logic                                slotValid1,
    input  logic                                slotValid2,
    input  logic                                slotValid3,
    input  logic                                slotValid4,
    input  logic [instQueuePkg::addrWidth-1:0]  slotAddr1, slotAddr2, slotAddr3, slotAddr4,
    input  logic [instQueuePkg::instWidth-1:0]  slotInst1, slotInst2, slotInst3, slotInst4,
    input  logic                                slotPart1, slotPart2, slotPart3, slotPart4,
    input  logic [instQueuePkg::addrWidth-1:0]  slotNextAddr1, slotNextAddr2,
                                                slotNextAddr3, slotNextAddr4,
    output logic                                bankWrEn1,
    output logic                                bankWrEn2,
    output logic                                bankWrEn3,
    output logic                                bankWrEn4,
    output logic [instQueuePkg::entryWidth-1:0] bankWrData1,
    output logic [instQueuePkg::entryWidth-1:0] bankWrData2,
    output logic [instQueuePkg::entryWidth-1:0] bankWrData3,
    output logic [instQueuePkg::entryWidth-1:0] bankWrData4
);

    logic [instQueuePkg::laneCount-1:0]  slotValid;
    logic [instQueuePkg::laneCount-1:0]  bankWrEn;
    logic [instQueuePkg::entryWidth-1:0] slotEntry [instQueuePkg::laneCount];
    logic [instQueuePkg::entryWidth-1:0] bankEntry [instQueuePkg::laneCount];

    assign slotValid    = {slotValid4, slotValid3, slotValid2, slotValid1};
    assign slotEntry[0] = {slotAddr1, slotInst1, slotPart1, slotNextAddr1};
    assign slotEntry[1] = {slotAddr2, slotInst2, slotPart2, slotNextAddr2};
    assign slotEntry[2] = {slotAddr3, slotInst3, slotPart3, slotNextAddr3};
    assign slotEntry[3] = {slotAddr4, slotInst4, slotPart4, slotNextAddr4};

    // Slot 1 lands in bank writePtr, so bank b takes slot (b - writePtr) mod 4.
    always_comb begin
        logic [instQueuePkg::ptrWidth-1:0] slotIdx;
        for (int b = 0; b < instQueuePkg::laneCount; b++) begin
            slotIdx      = b[instQueuePkg::ptrWidth-1:0] - writePtr;
            bankWrEn[b]  = slotValid[slotIdx];
            bankEntry[b] = slotEntry[slotIdx];
        end
    end

    assign {bankWrEn4, bankWrEn3, bankWrEn2, bankWrEn1} = bankWrEn;
    assign bankWrData1 = bankEntry[0];
    assign bankWrData2 = bankEntry[1];
    assign bankWrData3 = bankEntry[2];
    assign bankWrData4 = bankEntry[3];

endmodule

//--- verilog/instReadRotator.sv
`timescale 1ns/100ps

module instReadRotator (
    input  logic [instQueuePkg::ptrWidth-1:0]   outRotPtr,
    input  logic [instQueuePkg::issueWidth-1:0] outCount,
    input  logic [instQueuePkg::entryWidth-1:0] bankRdData1,
    input  logic [instQueuePkg::entryWidth-1:0] bankRdData2,
    input  logic [instQueuePkg::entryWidth-1:0] bankRdData3,
    input  logic [instQueuePkg::entryWidth-1:0] bankRdData4,
    output logic                                portValid1,
    output logic                                portValid2,
    output logic                                portValid3,
    output logic                                portValid4,
    output logic [instQueuePkg::addrWidth-1:0]  portAddr1, portAddr2, portAddr3, portAddr4,
    output logic [instQueuePkg::instWidth-1:0]  portInst1, portInst2, portInst3, portInst4,
    output logic                                portPart1, portPart2, portPart3, portPart4,
    output logic [instQueuePkg::addrWidth-1:0]  portNextAddr1, portNextAddr2,
                                                portNextAddr3, portNextAddr4
);

    logic [instQueuePkg::entryWidth-1:0] bankEntry [instQueuePkg::laneCount];
    logic [instQueuePkg::entryWidth-1:0] portEntry [instQueuePkg::laneCount];
    logic [instQueuePkg::laneCount-1:0]  portValid;

    assign bankEntry = '{bankRdData1, bankRdData2, bankRdData3, bankRdData4};

    //////////////////////////////////////////////////
    // Back to program order
    //////////////////////////////////////////////////

    always_comb begin
        logic [instQueuePkg::ptrWidth-1:0] bankIdx;
        for (int k = 0; k < instQueuePkg::laneCount; k++) begin
            bankIdx      = outRotPtr + k[instQueuePkg::ptrWidth-1:0];
            portEntry[k] = bankEntry[bankIdx];
            // Port k+1 is valid when at least k+1 instructions were read.
            portValid[k] = (outCount > k[instQueuePkg::issueWidth-1:0]);
        end
    end

    assign {portValid4, portValid3, portValid2, portValid1} = portValid;

    assign {portAddr1, portInst1, portPart1, portNextAddr1} = portEntry[0];
    assign {portAddr2, portInst2, portPart2, portNextAddr2} = portEntry[1];
    assign {portAddr3, portInst3, portPart3, portNextAddr3} = portEntry[2];
    assign {portAddr4, portInst4, portPart4, portNextAddr4} = portEntry[3];

endmodule

//--- verilog/instIssueQueue.sv
`timescale 1ns/100ps

module instIssueQueue (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               stop,
    input  logic                               flush,
    output logic                               reqStop,
    input  logic                               slotValid1, slotValid2, slotValid3, slotValid4,
    input  logic [instQueuePkg::addrWidth-1:0] slotAddr1, slotAddr2, slotAddr3, slotAddr4,
    input  logic [instQueuePkg::instWidth-1:0] slotInst1, slotInst2, slotInst3, slotInst4,
    input  logic                               slotPart1, slotPart2, slotPart3, slotPart4,
    input  logic [instQueuePkg::addrWidth-1:0] slotNextAddr1, slotNextAddr2,
                                               slotNextAddr3, slotNextAddr4,
    output logic                               portValid1, portValid2, portValid3, portValid4,
    output logic [instQueuePkg::addrWidth-1:0] portAddr1, portAddr2, portAddr3, portAddr4,
    output logic [instQueuePkg::instWidth-1:0] portInst1, portInst2, portInst3, portInst4,
    output logic                               portPart1, portPart2, portPart3, portPart4,
    output logic [instQueuePkg::addrWidth-1:0] portNextAddr1, portNextAddr2,
                                               portNextAddr3, portNextAddr4
);

    logic [instQueuePkg::ptrWidth-1:0]   writePtr;
    logic [instQueuePkg::ptrWidth-1:0]   outRotPtr;
    logic [instQueuePkg::issueWidth-1:0] outCount;
    logic                                bankWrEn1, bankWrEn2, bankWrEn3, bankWrEn4;
    logic                                bankRdEn1, bankRdEn2, bankRdEn3, bankRdEn4;
    logic                                bankEmpty1, bankEmpty2, bankEmpty3, bankEmpty4;
    logic [instQueuePkg::entryWidth-1:0] bankWrData1, bankWrData2, bankWrData3, bankWrData4;
    logic [instQueuePkg::entryWidth-1:0] bankRdData1, bankRdData2, bankRdData3, bankRdData4;
    logic [instQueuePkg::countWidth-1:0] bankCount1, bankCount2, bankCount3, bankCount4;

    // Port names of the three blocks below match the nets here one to one.
    instQueueCtrl    u_queueCtrl    (.*);
    instWriteRotator u_writeRotator (.*);
    instReadRotator  u_readRotator  (.*);

    //////////////////////////////////////////////////
    // Interleaved banks
    //////////////////////////////////////////////////

    instQueueBank u_bank1 (
        .Clk, .rstN, .clear(flush),
        .wrEn(bankWrEn1), .wrData(bankWrData1),
        .rdEn(bankRdEn1), .rdData(bankRdData1),
        .empty(bankEmpty1), .count(bankCount1)
    );

    instQueueBank u_bank2 (
        .Clk, .rstN, .clear(flush),
        .wrEn(bankWrEn2), .wrData(bankWrData2),
        .rdEn(bankRdEn2), .rdData(bankRdData2),
        .empty(bankEmpty2), .count(bankCount2)
    );

    instQueueBank u_bank3 (
        .Clk, .rstN, .clear(flush),
        .wrEn(bankWrEn3), .wrData(bankWrData3),
        .rdEn(bankRdEn3), .rdData(bankRdData3),
        .empty(bankEmpty3), .count(bankCount3)
    );

    instQueueBank u_bank4 (
        .Clk, .rstN, .clear(flush),
        .wrEn(bankWrEn4), .wrData(bankWrData4),
        .rdEn(bankRdEn4), .rdData(bankRdData4),
        .empty(bankEmpty4), .count(bankCount4)
    );

endmodule

//--- tb/instIssueQueue_sva.sv
`timescale 1ns/100ps

module instIssueQueue_sva (
    input logic Clk,
    input logic rstN,
    input logic stop,
    input logic flush,
    input logic reqStop,
    input logic slotValid1,
    input logic portValid1,
    input logic portValid2,
    input logic portValid3,
    input logic portValid4
);

    // Port k may only be valid when every port before it is.
    validPrefix: assert property (@(posedge Clk) disable iff (!rstN)
        (!portValid4 || portValid3) && (!portValid3 || portValid2) &&
        (!portValid2 || portValid1))
        else $error("Port valids do not form a prefix");

    // Slot 1 is valid in every group, so it stands for the whole write.
    noWriteOnReqStop: assert property (@(posedge Clk) disable iff (!rstN)
        reqStop |-> !slotValid1)
        else $error("Slot written while reqStop is high");

    quietAfterStop: assert property (@(posedge Clk) disable iff (!rstN)
        (stop || flush) |=> !portValid1)
        else $error("Port valid in the cycle after stop or flush");

    quietAfterReset: assert property (@(posedge Clk) !rstN |=> !portValid1)
        else $error("Port valid right after reset");

endmodule

//--- tb/tb_instIssueQueue.sv
`timescale 1ns/100ps

module tb_instIssueQueue;

    localparam logic [31:0] instKey = 32'h5a3c_96e1;   // Instruction word is address XOR this.
    localparam int drainLimit = 200;
    localparam int waitLimit  = 100;

    logic                                Clk;
    logic                                rstN;
    logic                                stop;
    logic                                flush;
    logic                                reqStop;
    logic [3:0]                          slotValid;
    logic [3:0]                          slotPart;
    logic [instQueuePkg::addrWidth-1:0]  slotAddr [4];
    logic [instQueuePkg::instWidth-1:0]  slotInst [4];
    logic [instQueuePkg::addrWidth-1:0]  slotNextAddr [4];
    logic [3:0]                          portValid;
    logic [3:0]                          portPart;
    logic [instQueuePkg::addrWidth-1:0]  portAddr [4];
    logic [instQueuePkg::instWidth-1:0]  portInst [4];
    logic [instQueuePkg::addrWidth-1:0]  portNextAddr [4];

    logic [31:0] expected [$];   // Addresses written and not yet seen on a port.
    int          errorCount = 0;
    int          testStart  = 0;
    int          testsRun   = 0;
    int          testsFailed = 0;
    int          seed       = 32'hd0e4;
    string       testName   = "";
    logic        abortRun   = 1'b0;
    logic        needFull   = 1'b0;
    logic        quietNow   = 1'b0;   // Stop or flush was high in the last cycle.
    logic        seenReqStop = 1'b0;

    instIssueQueue u_instIssueQueue (
        .Clk, .rstN, .stop, .flush, .reqStop,
        .slotValid1(slotValid[0]), .slotValid2(slotValid[1]),
        .slotValid3(slotValid[2]), .slotValid4(slotValid[3]),
        .slotAddr1(slotAddr[0]), .slotAddr2(slotAddr[1]),
        .slotAddr3(slotAddr[2]), .slotAddr4(slotAddr[3]),
        .slotInst1(slotInst[0]), .slotInst2(slotInst[1]),
        .slotInst3(slotInst[2]), .slotInst4(slotInst[3]),
        .slotPart1(slotPart[0]), .slotPart2(slotPart[1]),
        .slotPart3(slotPart[2]), .slotPart4(slotPart[3]),
        .slotNextAddr1(slotNextAddr[0]), .slotNextAddr2(slotNextAddr[1]),
        .slotNextAddr3(slotNextAddr[2]), .slotNextAddr4(slotNextAddr[3]),
        .portValid1(portValid[0]), .portValid2(portValid[1]),
        .portValid3(portValid[2]), .portValid4(portValid[3]),
        .portAddr1(portAddr[0]), .portAddr2(portAddr[1]),
        .portAddr3(portAddr[2]), .portAddr4(portAddr[3]),
        .portInst1(portInst[0]), .portInst2(portInst[1]),
        .portInst3(portInst[2]), .portInst4(portInst[3]),
        .portPart1(portPart[0]), .portPart2(portPart[1]),
        .portPart3(portPart[2]), .portPart4(portPart[3]),
        .portNextAddr1(portNextAddr[0]), .portNextAddr2(portNextAddr[1]),
        .portNextAddr3(portNextAddr[2]), .portNextAddr4(portNextAddr[3])
    );

    bind instIssueQueue instIssueQueue_sva u_sva (.*);

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Fields follow from the address, so the scoreboard only keeps addresses.
    task automatic setInputs(input logic stopIn, input logic flushIn, input int size,
                             input logic [31:0] base);
        logic [31:0] addr;
        stop  = stopIn;
        flush = flushIn;
        for (int k = 0; k < 4; k++) begin
            addr            = base + 32'(4 * k);
            slotValid[k]    = (k < size);
            slotAddr[k]     = addr;
            slotInst[k]     = addr ^ instKey;
            slotPart[k]     = addr[2];
            slotNextAddr[k] = addr + 32'd4;
            if (k < size) begin
                expected.push_back(addr);
            end
        end
    endtask

    task automatic runCycle(input logic stopIn, input logic flushIn, input int size,
                            input logic [31:0] base);
        #2;
        setInputs(stopIn, flushIn, size, base);
        @(posedge Clk);   // Returns on the edge that ends the cycle.
    endtask

    task automatic writeGroup(input logic stopIn, input int size, input logic [31:0] base);
        int waited;
        waited = 0;
        #2;
        while (reqStop && !abortRun) begin
            setInputs(1'b0, 1'b0, 0, base);   // Decode keeps draining meanwhile.
            @(posedge Clk);
            #2;
            waited++;
            if (waited > waitLimit) begin
                $display("Timeout: reqStop stayed high for %0d cycles", waited);
                errorCount++;
                abortRun = 1'b1;
            end
        end
        if (!abortRun) begin
            setInputs(stopIn, 1'b0, size, base);
        end
        @(posedge Clk);
    endtask

    task automatic fillQueue(input int groups, input logic [31:0] base);
        for (int g = 0; g < groups; g++) begin
            writeGroup(1'b1, 4, base + 32'(16 * g));
        end
    endtask

    task automatic streamGroups(input int groups, input logic [31:0] base);
        logic [31:0] addr;
        int          size;
        logic        stopNow;
        addr = base;
        for (int g = 0; g < groups && !abortRun; g++) begin
            size    = ($random(seed) & 3) + 1;
            stopNow = (($random(seed) & 3) == 0);
            writeGroup(stopNow, size, addr);
            addr    = addr + 32'(4 * size);
        end
    endtask

    task automatic flushQueue();
        runCycle(1'b0, 1'b1, 0, '0);
        expected.delete();   // Whatever was still in the banks is gone.
    endtask

    task automatic fullRate(input int cycles);
        needFull = 1'b1;
        repeat (cycles) runCycle(1'b0, 1'b0, 0, '0);
        needFull = 1'b0;
    endtask

    task automatic drainQueue();
        int waited;
        waited = 0;
        while (expected.size() > 0 && !abortRun) begin
            runCycle(1'b0, 1'b0, 0, '0);
            waited++;
            if (waited > drainLimit) begin
                $display("Timeout: %0d entries never reached decode", expected.size());
                errorCount++;
                abortRun = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic checkField(input string name, input int port, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s%0d: got 0x%h, expected 0x%h", name, port, got, want);
            errorCount++;
        end
    endtask

    task automatic checkPorts();
        logic [31:0] addr;
        if (quietNow && portValid != 4'b0000) begin
            $display("Fail portValid: got 0x%h, expected 0x0 after stop or flush", portValid);
            errorCount++;
        end
        if (needFull && portValid != 4'b1111) begin
            $display("Fail portValid: got 0x%h, expected 0xf", portValid);
            errorCount++;
        end
        for (int k = 0; k < 4; k++) begin
            if (portValid[k] && k > 0 && !portValid[k-1]) begin
                $display("Fail portValid: 0x%h is not a prefix", portValid);
                errorCount++;
            end
            if (portValid[k] && expected.size() == 0) begin
                $display("Port %0d presented 0x%h, which is not pending", k + 1, portAddr[k]);
                errorCount++;
            end else if (portValid[k]) begin
                addr = expected.pop_front();
                checkField("portAddr", k + 1, portAddr[k], addr);
                checkField("portInst", k + 1, portInst[k], addr ^ instKey);
                checkField("portPart", k + 1, 32'(portPart[k]), 32'(addr[2]));
                checkField("portNextAddr", k + 1, portNextAddr[k], addr + 32'd4);
            end
        end
        quietNow    = stop || flush;
        seenReqStop = reqStop;
    endtask

    always @(negedge Clk) begin
        if (rstN) begin
            checkPorts();
        end
    end

    task automatic checkPending(input int count);
        if (expected.size() != count) begin
            $display("Wrong number of entries in flight: %0d, expected %0d",
                     expected.size(), count);
            errorCount++;
        end
    endtask

    // Stop holds the banks still while reqStop is sampled.
    task automatic checkReqStop(input int value);
        runCycle(1'b1, 1'b0, 0, '0);
        if (seenReqStop !== 1'(value)) begin
            $display("Fail reqStop: got 0x%h, expected 0x%h", seenReqStop, 1'(value));
            errorCount++;
        end
    endtask

    task automatic endTest();
        if (testName != "") begin
            if (errorCount == testStart) begin
                $display("Test %s: PASS", testName);
            end else begin
                $display("Test %s: FAIL with %0d errors", testName, errorCount - testStart);
                testsFailed++;
            end
        end
        testName = "";
    endtask

    task automatic startTest(input string line);
        endTest();
        void'($sscanf(line, "%s", testName));
        testStart = errorCount;
        testsRun++;
    endtask

    task automatic runCommand(input int fd, input string cmd);
        string       line;
        int          n;
        logic [31:0] base;
        n    = 0;
        base = '0;
        line = "";
        void'($fgets(line, fd));
        void'($sscanf(line, "%d %h", n, base));
        case (cmd)
            "test":     startTest(line);
            "write":    writeGroup(1'b0, n, base);
            "fill":     fillQueue(n, base);
            "stream":   streamGroups(n, base);
            "idle":     repeat (n) runCycle(1'b0, 1'b0, 0, '0);
            "stop":     repeat (n) runCycle(1'b1, 1'b0, 0, '0);
            "flush":    flushQueue();
            "fullrate": fullRate(n);
            "drain":    drainQueue();
            "pending":  checkPending(n);
            "reqstop":  checkReqStop(n);
            default: begin
                if (cmd.substr(0, 0) != "#") begin
                    $display("Unknown command %s in the test file", cmd);
                    errorCount++;
                end
            end
        endcase
    endtask

    initial begin
        int    fd;
        string cmd;
        rstN = 1'b0;
        setInputs(1'b0, 1'b0, 0, '0);
        repeat (10) @(posedge Clk);
        #2 rstN = 1'b1;
        @(posedge Clk);
        fd = $fopen("tb/instQueueTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/instQueueTests.txt");
            errorCount++;
        end else begin
            while (!abortRun && $fscanf(fd, " %s", cmd) == 1) begin
                runCommand(fd, cmd);
            end
            $fclose(fd);
        end
        endTest();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb/instQueueTests.txt
# Columns: command, then its operands. Counts are decimal, addresses are hex.
# write n addr | fill groups addr | stream groups addr | idle/stop/fullrate cycles
# flush | drain | pending entries | reqstop value | test name

test reset
pending 0
reqstop 0
idle 3

test streaming
stream 80 00010000
drain
pending 0

test fullRate
fill 4 00002000
idle 1
fullrate 4
pending 0

test stop
fill 3 00003000
stop 4
pending 12
idle 2
pending 8
stop 3
pending 4
drain
pending 0

test reqStop
fill 6 00004000
reqstop 0
fill 1 00004060
reqstop 1
drain
reqstop 0

test flush
write 4 00005000
write 4 00005010
write 2 00005020
flush
idle 4
pending 0
write 3 00005100
drain
pending 0

//--- tb.f
verilog/instQueuePkg.sv
verilog/instQueueBank.sv
verilog/instQueueCtrl.sv
verilog/instWriteRotator.sv
verilog/instReadRotator.sv
verilog/instIssueQueue.sv
tb/instIssueQueue_sva.sv
tb/tb_instIssueQueue.sv

//--- Makefile
TOP = tb_instIssueQueue

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
